// File: Bender.yml
package:
  name: video_crop

sources:
  - hdl/crop_pkg.sv
  - hdl/line_timer.sv
  - hdl/frame_timer.sv
  - hdl/margin_keys.sv
  - hdl/crop_regs.sv
  - hdl/video_crop.sv
  - target: test
    files:
      - test/tb_video_crop.sv

// File: hdl/crop_pkg.sv
/*
 shared widths, key opcodes, register map and bus structs for the crop unit
 all positions and margins are 12 bit and wrap, no saturation anywhere
 sync is active low, blank is active high, source is progressive only
*/
package crop_pkg;

	localparam int pos_w = 12;                        // counters and margins
	localparam logic [pos_w-1:0] h_step = 12'd4;      // pixels per key press
	localparam logic [pos_w-1:0] v_step = 12'd1;      // lines per key press
	localparam logic [1:0] kbd_type_adjust = 2'd3;    // event type with adjust codes

	typedef enum logic [7:0] {
		key_reset    = 8'h41,
		key_up       = 8'h4C,
		key_down     = 8'h4D,
		key_right    = 8'h4E,
		key_left     = 8'h4F,
		key_alt_l    = 8'h64,
		key_alt_r    = 8'h65,
		key_alt_l_up = 8'hE4,
		key_alt_r_up = 8'hE5
	} key_code_e;

	typedef enum logic [3:0] {
		reg_margin_h  = 4'h0,   // left 11:0, right 27:16
		reg_margin_v  = 4'h4,   // top 11:0, bottom 27:16
		reg_mode_size = 4'h8,   // read only
		reg_status    = 4'hC    // read only
	} reg_addr_e;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hblank;
		logic vblank;
	} vid_timing_t;

	typedef struct packed {
		logic [pos_w-1:0] left;
		logic [pos_w-1:0] right;
		logic [pos_w-1:0] top;
		logic [pos_w-1:0] bottom;
	} margins_t;

	typedef struct packed {
		logic [pos_w-1:0] hsize;
		logic [pos_w-1:0] vsize;
		logic [1:0]       res;
	} mode_t;

	typedef struct packed {
		logic       strobe;     // toggles once per event
		logic [1:0] evt_type;
		logic [7:0] code;
	} kbd_evt_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

// File: hdl/crop_regs.sv
/*
 APB slave for margin presets and the mode snapshot, no wait states
 read data and slave error are registered in the setup phase
 the first frame after reset always counts as a mode change
*/
`timescale 1ns/1ns

module crop_regs (
	input  logic                                clk_28,
	input  logic                                rst_n,
	input  crop_pkg::apb_req_t                  apb_req,
	output crop_pkg::apb_rsp_t                  apb_rsp,
	input  crop_pkg::margins_t                  margins,
	input  logic [crop_pkg::pos_w-1:0]          hsize,
	input  logic [crop_pkg::pos_w-1:0]          vsize,
	input  logic [1:0]                          res,
	input  logic                                frame_start,
	output logic                                load,
	output logic                                load_h,
	output logic [1:0][crop_pkg::pos_w-1:0]     load_val
);
	import crop_pkg::*;

	logic        setup;
	logic        access;
	logic        addr_ok;
	logic        addr_ro;
	logic [31:0] rd_data;
	logic [31:0] prdata_q;
	logic        pslverr_q;
	mode_t       cur_mode;
	mode_t       snap;
	logic [6:0]  chg_cnt;

	assign setup  = apb_req.psel & ~apb_req.penable;
	assign access = apb_req.psel & apb_req.penable;

	always_comb begin
		addr_ok = 1'b1;
		addr_ro = 1'b0;
		rd_data = '0;
		case (apb_req.paddr)
			reg_margin_h:  rd_data = {4'h0, margins.right, 4'h0, margins.left};
			reg_margin_v:  rd_data = {4'h0, margins.bottom, 4'h0, margins.top};
			reg_mode_size: begin
				addr_ro = 1'b1;
				rd_data = {4'h0, snap.vsize, 4'h0, snap.hsize};
			end
			reg_status: begin
				addr_ro = 1'b1;
				rd_data = {17'h0, chg_cnt, 6'h0, snap.res};
			end
			default: addr_ok = 1'b0;
		endcase
	end

	// margin writes go straight to the margin store
	assign load        = access & apb_req.pwrite & addr_ok & ~addr_ro;
	assign load_h      = apb_req.paddr == reg_margin_h;
	assign load_val[0] = apb_req.pwdata[pos_w-1:0];
	assign load_val[1] = apb_req.pwdata[16 +: pos_w];

	always_ff @(posedge clk_28) begin
		if (setup) prdata_q <= apb_req.pwrite ? 32'h0 : rd_data;
	end

	always_ff @(posedge clk_28) begin
		if (!rst_n)
			pslverr_q <= 1'b0;
		else if (setup)
			pslverr_q <= ~addr_ok | (apb_req.pwrite & addr_ro);
		else if (!access)
			pslverr_q <= 1'b0;
	end

	assign apb_rsp.prdata  = prdata_q;
	assign apb_rsp.pready  = access;
	assign apb_rsp.pslverr = pslverr_q;

	//////////////////////////////////////////////////////////////////////
	// mode snapshot
	//////////////////////////////////////////////////////////////////////

	assign cur_mode = '{hsize: hsize, vsize: vsize, res: res};

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			snap    <= '0;
			chg_cnt <= '0;
		end else if (frame_start) begin
			snap <= cur_mode;
			if (cur_mode != snap) chg_cnt <= chg_cnt + 1'd1;   // wraps at 128
		end
	end

endmodule

// File: hdl/frame_timer.sv
/*
 vertical measurement, vertical crop blank and the display enable
 vertical blank is updated once per line, at the end of hbl
 crop lines are one line early since the compare runs before the line steps
*/
`timescale 1ns/1ns

module frame_timer (
	input  logic                          clk_28,
	input  logic                          rst_n,
	input  crop_pkg::vid_timing_t         vid,
	input  logic                          hbl,
	input  crop_pkg::margins_t            margins,
	output logic [crop_pkg::pos_w-1:0]    vsize,
	output logic                          frame_start,
	output logic                          de
);
	import crop_pkg::*;

	logic             old_vs;
	logic             old_hs;
	logic             old_vblank;
	logic             old_hbl;
	logic [pos_w-1:0] vcnt;
	logic [pos_w-1:0] first_act;    // first active line
	logic [pos_w-1:0] last_act;     // first blank line after active
	logic [pos_w-1:0] vmax;         // frame length in lines
	logic             svbl;         // margin blank
	logic             fvbl;         // forced blank, line 0 and last 3
	logic             hde;

	wire vblank      = vid.vblank | ~vid.vs;     // combined vertical blank
	wire vs_fall     = old_vs & ~vid.vs;
	wire hs_fall     = old_hs & ~vid.hs;
	wire vblank_fall = old_vblank & ~vblank;
	wire vblank_rise = ~old_vblank & vblank;
	wire hbl_end     = old_hbl & ~hbl;

	assign de = hde & ~svbl & ~fvbl;

	//////////////////////////////////////////////////////////////////////
	// line counter and edge capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_vs      <= 1'b1;
			old_hs      <= 1'b1;
			old_vblank  <= 1'b1;
			vcnt        <= '0;
			first_act   <= '0;
			last_act    <= '0;
			vmax        <= '0;
			vsize       <= '0;
			frame_start <= 1'b0;
		end else begin
			old_vs     <= vid.vs;
			old_hs     <= vid.hs;
			old_vblank <= vblank;

			if (!vid.vs)
				vcnt <= '0;
			else if (hs_fall)
				vcnt <= vcnt + 1'd1;

			if (vblank_fall) first_act <= vcnt;
			if (vs_fall)     vmax      <= vcnt;
			if (vblank_rise) begin
				last_act <= vcnt;
				vsize    <= vcnt - first_act;
			end

			frame_start <= vblank_fall;    // one cycle after the fall
		end
	end

	//////////////////////////////////////////////////////////////////////
	// vertical crop and enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_hbl <= 1'b1;
			svbl    <= 1'b1;
			fvbl    <= 1'b1;
			hde     <= 1'b0;
		end else begin
			old_hbl <= hbl;
			hde     <= ~hbl;
			if (hbl_end) begin
				if (vcnt == first_act + margins.top - 1'd1)   svbl <= 1'b0;
				if (vcnt == last_act + margins.bottom - 1'd1) svbl <= 1'b1;

				if (vcnt == pos_w'(1))        fvbl <= 1'b0;
				if (vcnt == vmax - pos_w'(3)) fvbl <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/line_timer.sv
/*
 horizontal measurement and crop blank, one pixel per clk_28
 crop edges land 2 pixels early to line up with the registered de
 margins that push an edge outside the line never match and leave it stuck
*/
`timescale 1ns/1ns

module line_timer (
	input  logic                          clk_28,
	input  logic                          rst_n,
	input  crop_pkg::vid_timing_t         vid,
	input  crop_pkg::margins_t            margins,
	output logic                          hbl,
	output logic [crop_pkg::pos_w-1:0]    hsize
);
	import crop_pkg::*;

	logic             old_hs;
	logic             old_hblank;
	logic [pos_w-1:0] hcnt;
	logic [pos_w-1:0] act_start;    // first active pixel
	logic [pos_w-1:0] act_end;      // first blank pixel after active
	logic [pos_w-1:0] hmax;         // line length
	logic             shbl;         // margin blank
	logic             fhbl;         // forced blank near the line ends

	wire hs_fall     = old_hs & ~vid.hs;
	wire hblank_fall = old_hblank & ~vid.hblank;
	wire hblank_rise = ~old_hblank & vid.hblank;

	assign hbl = fhbl | shbl | ~vid.hs;

	//////////////////////////////////////////////////////////////////////
	// pixel counter and edge capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b1;
			hcnt       <= '0;
			act_start  <= '0;
			act_end    <= '0;
			hmax       <= '0;
			hsize      <= '0;
		end else begin
			old_hs     <= vid.hs;
			old_hblank <= vid.hblank;

			if (!vid.hs)
				hcnt <= '0;                     // held during sync
			else
				hcnt <= hcnt + 1'd1;

			if (hblank_fall) act_start <= hcnt;
			if (hs_fall)     hmax      <= hcnt;
			if (hblank_rise) begin
				act_end <= hcnt;
				hsize   <= hcnt - act_start;    // active width of this line
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// crop blank
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
		end else begin
			if (hcnt == act_start + margins.left - 2'd2) shbl <= 1'b0;
			if (hcnt == act_end + margins.right - 2'd2)  shbl <= 1'b1;

			if (hcnt == pos_w'(8))        fhbl <= 1'b0;
			if (hcnt == hmax - pos_w'(8)) fhbl <= 1'b1;   // last 8 pixels
		end
	end

endmodule

// File: hdl/margin_keys.sv
/*
 crop margin store, adjusted by keyboard codes or loaded over APB
 a key acts two cycles after the strobe rises, a load in the same cycle wins
 margins wrap, so stepping below zero gives a large margin
*/
`timescale 1ns/1ns

module margin_keys (
	input  logic                                clk_28,
	input  logic                                rst_n,
	input  crop_pkg::kbd_evt_t                  kbd,
	input  logic                                load,
	input  logic                                load_h,
	input  logic [1:0][crop_pkg::pos_w-1:0]     load_val,
	output crop_pkg::margins_t                  margins
);
	import crop_pkg::*;

	logic       old_stb;
	logic       key_stb;    // registered strobe edge
	logic [7:0] key_q;
	logic       alt;

	wire adj_stb  = kbd.strobe & (kbd.evt_type == kbd_type_adjust);
	wire adj_rise = adj_stb & ~old_stb;

	always_ff @(posedge clk_28) begin
		if (adj_rise) key_q <= kbd.code;
	end

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_stb <= 1'b0;
			key_stb <= 1'b0;
			alt     <= 1'b0;
			margins <= '0;
		end else begin
			old_stb <= adj_stb;
			key_stb <= adj_rise;

			if (key_stb) begin
				case (key_q)
					key_reset: margins <= '0;
					key_up:    if (alt) margins.bottom <= margins.bottom + v_step;
					           else     margins.top    <= margins.top + v_step;
					key_down:  if (alt) margins.bottom <= margins.bottom - v_step;
					           else     margins.top    <= margins.top - v_step;
					key_left:  if (alt) margins.right  <= margins.right + h_step;
					           else     margins.left   <= margins.left + h_step;
					key_right: if (alt) margins.right  <= margins.right - h_step;
					           else     margins.left   <= margins.left - h_step;
					key_alt_l, key_alt_r:       alt <= 1'b1;
					key_alt_l_up, key_alt_r_up: alt <= 1'b0;
					default: ;                  // other codes ignored
				endcase
			end

			if (load) begin
				if (load_h) begin
					margins.left  <= load_val[0];
					margins.right <= load_val[1];
				end else begin
					margins.top    <= load_val[0];
					margins.bottom <= load_val[1];
				end
			end
		end
	end

endmodule

// File: hdl/video_crop.sv
/*
 video crop unit top, all blocks in the clk_28 pixel domain
 inputs are expected already synchronous to clk_28
*/
`timescale 1ns/1ns

module video_crop (
	input  logic                     clk_28,
	input  logic                     rst_n,
	input  crop_pkg::vid_timing_t    vid,
	input  logic [1:0]               res,
	input  crop_pkg::kbd_evt_t       kbd,
	input  crop_pkg::apb_req_t       apb_req,
	output crop_pkg::apb_rsp_t       apb_rsp,
	output logic                     de
);
	import crop_pkg::*;

	margins_t                margins;
	logic                    hbl;
	logic [pos_w-1:0]        hsize;
	logic [pos_w-1:0]        vsize;
	logic                    frame_start;
	logic                    load;
	logic                    load_h;
	logic [1:0][pos_w-1:0]   load_val;

	line_timer line_timer_inst (
		.clk_28  (clk_28),
		.rst_n   (rst_n),
		.vid     (vid),
		.margins (margins),
		.hbl     (hbl),
		.hsize   (hsize)
	);

	frame_timer frame_timer_inst (
		.clk_28      (clk_28),
		.rst_n       (rst_n),
		.vid         (vid),
		.hbl         (hbl),
		.margins     (margins),
		.vsize       (vsize),
		.frame_start (frame_start),
		.de          (de)
	);

	margin_keys margin_keys_inst (
		.clk_28   (clk_28),
		.rst_n    (rst_n),
		.kbd      (kbd),
		.load     (load),
		.load_h   (load_h),
		.load_val (load_val),
		.margins  (margins)
	);

	crop_regs crop_regs_inst (
		.clk_28      (clk_28),
		.rst_n       (rst_n),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.margins     (margins),
		.hsize       (hsize),
		.vsize       (vsize),
		.res         (res),
		.frame_start (frame_start),
		.load        (load),
		.load_h      (load_h),
		.load_val    (load_val)
	);

endmodule

// File: src.f
hdl/crop_pkg.sv
hdl/line_timer.sv
hdl/frame_timer.sv
hdl/margin_keys.sv
hdl/crop_regs.sv
hdl/video_crop.sv
test/tb_video_crop.sv

// File: test/tb_video_crop.sv
/*
 testbench for the video crop unit with random stimulus seeded with 7
 the source is progressive and idles in sync between frames
 margins stay small while de is counted, so the forced blank is never hit
*/
`timescale 1ns/1ns

module tb_video_crop;
	import crop_pkg::*;

	logic        clk_28;
	logic        rst_n;
	vid_timing_t vid;
	logic [1:0]  res;
	kbd_evt_t    kbd;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        de;
	int          errors;

	int          line_len;      // source mode in pixels and lines
	int          sync_len;
	int          act_start;
	int          act_end;
	int          frame_len;
	int          vsync_len;
	int          vact_start;
	int          vact_end;
	logic [1:0]  mode_res;

	margins_t    m_marg;        // reference model state
	logic        m_alt;
	logic [11:0] m_hsize;
	logic [11:0] m_vsize;
	mode_t       m_snap;
	logic [6:0]  m_chg;

	video_crop video_crop_inst (
		.clk_28  (clk_28),
		.rst_n   (rst_n),
		.vid     (vid),
		.res     (res),
		.kbd     (kbd),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.de      (de)
	);

	always #4 clk_28 = ~clk_28;

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// register map model and APB driver
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] model_reg(input logic [3:0] addr);
		case (addr)
			reg_margin_h:  return {4'h0, m_marg.right, 4'h0, m_marg.left};
			reg_margin_v:  return {4'h0, m_marg.bottom, 4'h0, m_marg.top};
			reg_mode_size: return {4'h0, m_snap.vsize, 4'h0, m_snap.hsize};
			reg_status:    return {17'h0, m_chg, 6'h0, m_snap.res};
			default:       return 32'h0;
		endcase
	endfunction

	function automatic logic bus_error(input logic wr, input logic [3:0] addr);
		case (addr)
			reg_margin_h, reg_margin_v: return 1'b0;
			reg_mode_size, reg_status:  return wr;    // read only
			default:                    return 1'b1;
		endcase
	endfunction

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int n;
		@(negedge clk_28);
		apb_req.psel    = 1'b1;                   // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk_28);
		apb_req.penable = 1'b1;
		n = 0;
		@(posedge clk_28);
		check("pready", apb_rsp.pready, 1'b1);    // no wait states
		while (!apb_rsp.pready && n < 16) begin
			@(posedge clk_28);
			n++;
		end
		if (!apb_rsp.pready) begin
			errors++;
			$display("APB slave gave no pready at address 0x%h", addr);
			finish_run();
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge clk_28);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b1, addr, data, rdata, err);
		check("pslverr", err, bus_error(1'b1, addr));
		if (addr == reg_margin_h) begin
			m_marg.left  = data[11:0];
			m_marg.right = data[27:16];
		end else if (addr == reg_margin_v) begin
			m_marg.top    = data[11:0];
			m_marg.bottom = data[27:16];
		end
	endtask

	task automatic read_reg(input string name, input logic [3:0] addr);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b0, addr, $urandom, rdata, err);
		check(name, rdata, model_reg(addr));
		check("pslverr", err, bus_error(1'b0, addr));
	endtask

	task automatic read_all();
		read_reg("margin_h", reg_margin_h);
		read_reg("margin_v", reg_margin_v);
		read_reg("mode_size", reg_mode_size);
		read_reg("status", reg_status);
	endtask

	//////////////////////////////////////////////////////////////////////
	// keyboard driver and model
	//////////////////////////////////////////////////////////////////////

	task automatic model_key(input logic [7:0] code);
		case (code)
			key_reset: m_marg = '0;
			key_up:    if (m_alt) m_marg.bottom += v_step;
			           else       m_marg.top    += v_step;
			key_down:  if (m_alt) m_marg.bottom -= v_step;
			           else       m_marg.top    -= v_step;
			key_left:  if (m_alt) m_marg.right  += h_step;
			           else       m_marg.left   += h_step;
			key_right: if (m_alt) m_marg.right  -= h_step;
			           else       m_marg.left   -= h_step;
			key_alt_l, key_alt_r:       m_alt = 1'b1;
			key_alt_l_up, key_alt_r_up: m_alt = 1'b0;
			default: ;
		endcase
	endtask

	function automatic logic [7:0] random_code();
		case ($urandom % 10)
			0:       return key_reset;
			1:       return key_up;
			2:       return key_down;
			3:       return key_left;
			4:       return key_right;
			5:       return key_alt_l;
			6:       return key_alt_r;
			7:       return key_alt_l_up;
			8:       return key_alt_r_up;
			default: return $urandom % 256;    // mostly unknown codes
		endcase
	endfunction

	task automatic send_key(input logic [1:0] evt_type, input logic [7:0] code);
		@(negedge clk_28);
		kbd.strobe   = ~kbd.strobe;
		kbd.evt_type = evt_type;
		kbd.code     = code;
		if (kbd.strobe && evt_type == kbd_type_adjust)
			model_key(code);                      // only a rising strobe acts
		repeat (3 + $urandom % 3) @(negedge clk_28);
	endtask

	//////////////////////////////////////////////////////////////////////
	// video source
	//////////////////////////////////////////////////////////////////////

	task automatic new_mode();
		line_len   = 60 + $urandom % 31;
		sync_len   = 4 + $urandom % 4;
		act_start  = 12 + $urandom % 8;
		act_end    = line_len - sync_len - 14 - $urandom % 6;
		frame_len  = 20 + $urandom % 11;
		vsync_len  = 2 + $urandom % 2;
		vact_start = 3 + $urandom % 3;
		vact_end   = frame_len - vsync_len - 5 - $urandom % 3;
		mode_res   = $urandom % 4;
	endtask

	task automatic take_snapshot();
		mode_t cur;
		cur = '{hsize: m_hsize, vsize: m_vsize, res: mode_res};
		if (cur != m_snap)
			m_chg++;
		m_snap = cur;
	endtask

	task automatic run_frame(input bit measure);
		int line_de;
		int de_lines;
		de_lines = 0;
		for (int ln = 0; ln < frame_len; ln++) begin
			line_de = 0;
			for (int p = 0; p < line_len; p++) begin
				@(negedge clk_28);
				if (de)
					line_de++;                    // de of the pixel now in the DUT
				res        = mode_res;
				vid.hs     = p < line_len - sync_len;
				vid.vs     = ln < frame_len - vsync_len;
				vid.hblank = p < act_start || p >= act_end;
				vid.vblank = ln < vact_start || ln >= vact_end;
				if (p == act_end)
					m_hsize = act_end - act_start;
				if (p == 0 && ln == vact_end)
					m_vsize = vact_end - vact_start;
				if (p == 0 && ln == vact_start)
					take_snapshot();
			end
			if (measure && line_de > 0) begin
				de_lines++;
				check("de cycles per line", line_de,
					act_end - act_start - m_marg.left + m_marg.right);
			end
		end
		if (measure)
			check("de lines per frame", de_lines,
				vact_end - vact_start - m_marg.top + m_marg.bottom);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [1:0] evt_type;
		void'($urandom(7));
		clk_28  = 1'b0;
		rst_n   = 1'b0;
		vid     = '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1};    // idle in sync
		res     = 2'd0;
		kbd     = '0;
		apb_req = '0;
		errors  = 0;
		m_marg  = '0;
		m_alt   = 1'b0;
		m_hsize = '0;
		m_vsize = '0;
		m_snap  = '0;
		m_chg   = '0;
		repeat (4) @(negedge clk_28);
		rst_n = 1'b1;

		read_all();                               // reset values
		check("de", de, 1'b0);

		write_reg(reg_margin_h, $urandom);
		write_reg(reg_margin_v, $urandom);
		read_all();
		write_reg(reg_mode_size, $urandom);
		write_reg(reg_status, $urandom);
		write_reg(4'((($urandom % 4) * 4) + 1 + $urandom % 3), $urandom);
		read_all();

		repeat (60) begin
			evt_type = ($urandom % 4 == 0) ? 2'($urandom % 3) : kbd_type_adjust;
			send_key(evt_type, random_code());
		end
		read_all();

		repeat (4) begin                          // mode switches
			new_mode();
			run_frame(1'b0);
			run_frame(1'b0);
			read_all();
			run_frame(1'b0);
			read_reg("status", reg_status);
		end

		repeat (2) begin                          // de counts with small margins
			write_reg(reg_margin_h, {4'h0, 12'($urandom % 8), 4'h0, 12'($urandom % 8)});
			write_reg(reg_margin_v, {4'h0, 12'($urandom % 4), 4'h0, 12'($urandom % 4)});
			run_frame(1'b0);
			run_frame(1'b1);
		end

		finish_run();
	end

endmodule
